//--- hw/decoder_pkg.sv
package decoder_pkg;

    // lattice extent, rows x columns x measurement layers
    localparam int CODE_DISTANCE = 3;
    localparam int ROW_COUNT = CODE_DISTANCE;
    localparam int COLUMN_COUNT = CODE_DISTANCE - 1;
    localparam int LAYER_COUNT = CODE_DISTANCE - 1;
    localparam int PU_COUNT = ROW_COUNT * COLUMN_COUNT * LAYER_COUNT;
    localparam int PU_INDEX_WIDTH = $clog2(PU_COUNT);

    // row edges, column edges, then edges between layers
    localparam int EDGE_COUNT = (ROW_COUNT - 1) * COLUMN_COUNT * LAYER_COUNT
        + ROW_COUNT * (COLUMN_COUNT - 1) * LAYER_COUNT
        + ROW_COUNT * COLUMN_COUNT * (LAYER_COUNT - 1);

    localparam int NEIGHBOR_COST = 2;
    localparam int BOUNDARY_COST = 2;
    localparam int GROWTH_WIDTH = $clog2(NEIGHBOR_COST + 1);
    localparam int MAX_NEIGHBORS = 6;

    // neighbor slot order inside a unit
    localparam int DIR_BOTTOM = 0;
    localparam int DIR_TOP = 1;
    localparam int DIR_LEFT = 2;
    localparam int DIR_RIGHT = 3;
    localparam int DIR_DOWN = 4;
    localparam int DIR_UP = 5;

    typedef enum logic [1:0] {
        STAGE_IDLE,
        STAGE_MEASUREMENT_LOADING,
        STAGE_GROW,
        STAGE_MERGE
    } stage_e;

    function automatic int pu_index(int i, int j, int k);
        return i * COLUMN_COUNT + j + k * ROW_COUNT * COLUMN_COUNT;
    endfunction

    function automatic bit has_boundary(int j, int k);
        return (j == 0) || (j == COLUMN_COUNT - 1) || (k == 0);
    endfunction

    function automatic bit neighbor_exists(int i, int j, int k, int dir);
        case (dir)
            DIR_BOTTOM: return i > 0;
            DIR_TOP: return i < ROW_COUNT - 1;
            DIR_LEFT: return j > 0;
            DIR_RIGHT: return j < COLUMN_COUNT - 1;
            DIR_DOWN: return k > 0;
            DIR_UP: return k < LAYER_COUNT - 1;
            default: return 1'b0;
        endcase
    endfunction

    // missing neighbors take no slot, so later directions shift down
    function automatic int neighbor_slot(int i, int j, int k, int dir);
        int slot;
        slot = 0;
        for (int d = 0; d < dir; d++) begin
            if (neighbor_exists(i, j, k, d)) begin
                slot++;
            end
        end
        return slot;
    endfunction

    function automatic int neighbor_count(int i, int j, int k);
        return neighbor_slot(i, j, k, MAX_NEIGHBORS);
    endfunction

endpackage

//--- hw/neighbor_link.sv
module neighbor_link (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   load_i,
    input  logic                                   grow_i,
    input  logic                                   a_occupied_i,
    input  logic                                   b_occupied_i,
    input  logic [decoder_pkg::PU_INDEX_WIDTH-1:0] a_root_i,
    input  logic [decoder_pkg::PU_INDEX_WIDTH-1:0] b_root_i,
    output logic [decoder_pkg::PU_INDEX_WIDTH-1:0] a_root_o,
    output logic [decoder_pkg::PU_INDEX_WIDTH-1:0] b_root_o,
    output logic                                   is_fully_grown_o
);
    import decoder_pkg::*;

    logic [GROWTH_WIDTH-1:0] growth_q;
    logic [GROWTH_WIDTH:0]   growth_sum;

    // each occupied end pushes the edge by one per step
    assign growth_sum = {1'b0, growth_q}
        + {{GROWTH_WIDTH{1'b0}}, a_occupied_i}
        + {{GROWTH_WIDTH{1'b0}}, b_occupied_i};

    always_ff @(posedge clk) begin
        if (reset || load_i) begin
            growth_q <= '0;
        end else if (grow_i) begin
            if (growth_sum >= NEIGHBOR_COST) begin
                growth_q <= GROWTH_WIDTH'(NEIGHBOR_COST);
            end else begin
                growth_q <= growth_sum[GROWTH_WIDTH-1:0];
            end
        end
    end

    assign is_fully_grown_o = (growth_q == GROWTH_WIDTH'(NEIGHBOR_COST));

    // each side sees the root held on the far side
    assign a_root_o = b_root_i;
    assign b_root_o = a_root_i;

    growth_saturates: assert property (
        @(posedge clk) disable iff (reset)
        growth_q <= NEIGHBOR_COST
    ) else $error("edge growth %0d past its length", growth_q);

endmodule

//--- hw/processing_unit.sv
module processing_unit #(
    parameter int SELF_INDEX = 0,
    parameter int NEIGHBOR_COUNT = 1,
    parameter bit HAS_BOUNDARY = 1'b0
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   load_i,
    input  logic                                   grow_i,
    input  logic                                   merge_i,
    input  logic                                   is_error_syndrome_i,
    input  logic [NEIGHBOR_COUNT-1:0]              neighbor_fully_grown_i,
    input  logic [NEIGHBOR_COUNT-1:0][decoder_pkg::PU_INDEX_WIDTH-1:0]
                                                   neighbor_root_i,
    output logic                                   is_occupied_o,
    output logic [decoder_pkg::PU_INDEX_WIDTH-1:0] root_o,
    output logic                                   is_touching_boundary_o,
    output logic                                   changed_o
);
    import decoder_pkg::*;

    logic                      is_error_syndrome_q;
    logic [GROWTH_WIDTH-1:0]   boundary_growth_q;
    logic [PU_INDEX_WIDTH-1:0] root_q;
    logic [PU_INDEX_WIDTH-1:0] smallest_root;

    // a fully grown edge always has an occupied end, so occupancy spreads across it
    assign is_occupied_o = is_error_syndrome_q | (|neighbor_fully_grown_i);

    assign is_touching_boundary_o = (boundary_growth_q == GROWTH_WIDTH'(BOUNDARY_COST));

    assign root_o = root_q;

    // smallest root among self and the neighbors joined by a full edge
    always_comb begin
        smallest_root = root_q;
        for (int n = 0; n < NEIGHBOR_COUNT; n++) begin
            if (neighbor_fully_grown_i[n] && (neighbor_root_i[n] < smallest_root)) begin
                smallest_root = neighbor_root_i[n];
            end
        end
    end

    assign changed_o = merge_i && (smallest_root != root_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            is_error_syndrome_q <= 1'b0;
            boundary_growth_q <= '0;
            root_q <= PU_INDEX_WIDTH'(SELF_INDEX);
        end else if (load_i) begin
            // new round starts from the syndrome alone
            is_error_syndrome_q <= is_error_syndrome_i;
            boundary_growth_q <= '0;
            root_q <= PU_INDEX_WIDTH'(SELF_INDEX);
        end else if (grow_i) begin
            if (HAS_BOUNDARY && is_occupied_o && !is_touching_boundary_o) begin
                boundary_growth_q <= boundary_growth_q + 1'b1;
            end
        end else if (merge_i) begin
            root_q <= smallest_root;
        end
    end

    // roots start at the own index and only ever move to smaller ones
    root_not_above_self: assert property (
        @(posedge clk) disable iff (reset)
        root_q <= SELF_INDEX
    ) else $error("unit %0d holds root %0d", SELF_INDEX, root_q);

endmodule

//--- hw/stage_control.sv
module stage_control (
    input  logic                               clk,
    input  logic                               reset,
    input  decoder_pkg::stage_e                stage_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]   changed_i,
    output logic                               load_o,
    output logic                               grow_o,
    output logic                               merge_o,
    output logic                               busy_o
);
    import decoder_pkg::*;

    stage_e stage_q;
    stage_e stage_prev_q;

    // stage is delayed by one cycle to line up with the units
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= STAGE_IDLE;
            stage_prev_q <= STAGE_IDLE;
        end else begin
            stage_q <= stage_i;
            stage_prev_q <= stage_q;
        end
    end

    // entry into a stage gives a single cycle pulse
    assign load_o = (stage_q == STAGE_MEASUREMENT_LOADING)
        && (stage_prev_q != STAGE_MEASUREMENT_LOADING);
    assign grow_o = (stage_q == STAGE_GROW) && (stage_prev_q != STAGE_GROW);
    assign merge_o = (stage_q == STAGE_MERGE);

    // some root still moved in the last merge cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_o <= 1'b0;
        end else begin
            busy_o <= |changed_i;
        end
    end

    load_grow_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(load_o && grow_o)
    ) else $error("load and grow pulses overlap");

endmodule

//--- hw/union_find_decoder.sv
module union_find_decoder (
    input  logic                                   clk,
    input  logic                                   reset,
    input  decoder_pkg::stage_e                    stage_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]       is_error_syndrome_i,
    output wire  [decoder_pkg::PU_COUNT-1:0][decoder_pkg::PU_INDEX_WIDTH-1:0]
                                                   root_o,
    output wire  [decoder_pkg::PU_COUNT-1:0]       is_occupied_o,
    output wire  [decoder_pkg::PU_COUNT-1:0]       is_touching_boundary_o,
    output wire                                    busy_o
);
    import decoder_pkg::*;

    wire                    load;
    wire                    grow;
    wire                    merge;
    wire [PU_COUNT-1:0]     changed;

    // per unit neighbor slots, only the first neighbor_count entries exist
    wire [PU_COUNT-1:0][MAX_NEIGHBORS-1:0]                     nbr_grown;
    wire [PU_COUNT-1:0][MAX_NEIGHBORS-1:0][PU_INDEX_WIDTH-1:0] nbr_root;

    stage_control u_stage_control (
        .clk       (clk),
        .reset     (reset),
        .stage_i   (stage_i),
        .changed_i (changed),
        .load_o    (load),
        .grow_o    (grow),
        .merge_o   (merge),
        .busy_o    (busy_o)
    );

    for (genvar gk = 0; gk < LAYER_COUNT; gk++) begin : g_layer
        for (genvar gi = 0; gi < ROW_COUNT; gi++) begin : g_row
            for (genvar gj = 0; gj < COLUMN_COUNT; gj++) begin : g_col
                processing_unit #(
                    .SELF_INDEX     (pu_index(gi, gj, gk)),
                    .NEIGHBOR_COUNT (neighbor_count(gi, gj, gk)),
                    .HAS_BOUNDARY   (has_boundary(gj, gk))
                ) u_pu (
                    .clk                    (clk),
                    .reset                  (reset),
                    .load_i                 (load),
                    .grow_i                 (grow),
                    .merge_i                (merge),
                    .is_error_syndrome_i    (is_error_syndrome_i[pu_index(gi, gj, gk)]),
                    .neighbor_fully_grown_i (
                        nbr_grown[pu_index(gi, gj, gk)][neighbor_count(gi, gj, gk)-1:0]),
                    .neighbor_root_i        (
                        nbr_root[pu_index(gi, gj, gk)][neighbor_count(gi, gj, gk)-1:0]),
                    .is_occupied_o          (is_occupied_o[pu_index(gi, gj, gk)]),
                    .root_o                 (root_o[pu_index(gi, gj, gk)]),
                    .is_touching_boundary_o (is_touching_boundary_o[pu_index(gi, gj, gk)]),
                    .changed_o              (changed[pu_index(gi, gj, gk)])
                );

                // one link per forward direction: top, right, up
                for (genvar gd = 0; gd < 3; gd++) begin : g_dir
                    if (neighbor_exists(gi, gj, gk, 2 * gd + 1)) begin : g_link
                        wire fully_grown;

                        neighbor_link u_link (
                            .clk              (clk),
                            .reset            (reset),
                            .load_i           (load),
                            .grow_i           (grow),
                            .a_occupied_i     (is_occupied_o[pu_index(gi, gj, gk)]),
                            .b_occupied_i     (is_occupied_o[
                                pu_index(gi + (gd == 0), gj + (gd == 1), gk + (gd == 2))]),
                            .a_root_i         (root_o[pu_index(gi, gj, gk)]),
                            .b_root_i         (root_o[
                                pu_index(gi + (gd == 0), gj + (gd == 1), gk + (gd == 2))]),
                            .a_root_o         (nbr_root[pu_index(gi, gj, gk)]
                                [neighbor_slot(gi, gj, gk, 2 * gd + 1)]),
                            .b_root_o         (nbr_root[
                                pu_index(gi + (gd == 0), gj + (gd == 1), gk + (gd == 2))]
                                [neighbor_slot(gi + (gd == 0), gj + (gd == 1),
                                    gk + (gd == 2), 2 * gd)]),
                            .is_fully_grown_o (fully_grown)
                        );

                        // both ends see the same edge state
                        assign nbr_grown[pu_index(gi, gj, gk)]
                            [neighbor_slot(gi, gj, gk, 2 * gd + 1)] = fully_grown;
                        assign nbr_grown[
                            pu_index(gi + (gd == 0), gj + (gd == 1), gk + (gd == 2))]
                            [neighbor_slot(gi + (gd == 0), gj + (gd == 1),
                                gk + (gd == 2), 2 * gd)] = fully_grown;
                    end
                end
            end
        end
    end

endmodule

//--- sources.f
+incdir+tests
hw/decoder_pkg.sv
hw/stage_control.sv
hw/processing_unit.sv
hw/neighbor_link.sv
hw/union_find_decoder.sv
tests/decoder_tb.sv

//--- tests/decoder_model.svh
`ifndef DECODER_MODEL_SVH
`define DECODER_MODEL_SVH

typedef logic [PU_COUNT-1:0][PU_INDEX_WIDTH-1:0] root_vec_t;

// edge endpoints and growth, one entry per lattice edge
int edge_a [EDGE_COUNT];
int edge_b [EDGE_COUNT];
int edge_growth [EDGE_COUNT];

bit model_syndrome [PU_COUNT];
bit model_boundary [PU_COUNT];
int model_boundary_growth [PU_COUNT];

// returns the number of edges found, which should be EDGE_COUNT
function automatic int build_edges();
    int e;
    e = 0;
    for (int k = 0; k < LAYER_COUNT; k++) begin
        for (int i = 0; i < ROW_COUNT; i++) begin
            for (int j = 0; j < COLUMN_COUNT; j++) begin
                model_boundary[pu_index(i, j, k)] = has_boundary(j, k);
                if (i + 1 < ROW_COUNT) begin
                    edge_a[e] = pu_index(i, j, k);
                    edge_b[e] = pu_index(i + 1, j, k);
                    e++;
                end
                if (j + 1 < COLUMN_COUNT) begin
                    edge_a[e] = pu_index(i, j, k);
                    edge_b[e] = pu_index(i, j + 1, k);
                    e++;
                end
                if (k + 1 < LAYER_COUNT) begin
                    edge_a[e] = pu_index(i, j, k);
                    edge_b[e] = pu_index(i, j, k + 1);
                    e++;
                end
            end
        end
    end
    return e;
endfunction

function automatic void model_load(logic [PU_COUNT-1:0] syndromes);
    for (int u = 0; u < PU_COUNT; u++) begin
        model_syndrome[u] = syndromes[u];
        model_boundary_growth[u] = 0;
    end
    for (int e = 0; e < EDGE_COUNT; e++) begin
        edge_growth[e] = 0;
    end
endfunction

// a unit is occupied by its syndrome or by any full edge that ends at it
function automatic logic [PU_COUNT-1:0] model_occupied();
    logic [PU_COUNT-1:0] occupied;
    for (int u = 0; u < PU_COUNT; u++) begin
        occupied[u] = model_syndrome[u];
    end
    for (int e = 0; e < EDGE_COUNT; e++) begin
        if (edge_growth[e] == NEIGHBOR_COST) begin
            occupied[edge_a[e]] = 1'b1;
            occupied[edge_b[e]] = 1'b1;
        end
    end
    return occupied;
endfunction

function automatic logic [PU_COUNT-1:0] model_touching();
    logic [PU_COUNT-1:0] touching;
    for (int u = 0; u < PU_COUNT; u++) begin
        touching[u] = (model_boundary_growth[u] == BOUNDARY_COST);
    end
    return touching;
endfunction

// one growth step, driven by the occupancy before the step
function automatic void model_grow();
    logic [PU_COUNT-1:0] occupied;
    int sum;
    occupied = model_occupied();
    for (int e = 0; e < EDGE_COUNT; e++) begin
        sum = edge_growth[e] + occupied[edge_a[e]] + occupied[edge_b[e]];
        edge_growth[e] = (sum > NEIGHBOR_COST) ? NEIGHBOR_COST : sum;
    end
    for (int u = 0; u < PU_COUNT; u++) begin
        if (model_boundary[u] && occupied[u] && model_boundary_growth[u] < BOUNDARY_COST) begin
            model_boundary_growth[u]++;
        end
    end
endfunction

// smallest index in each component of full edges
function automatic root_vec_t model_roots();
    int label [PU_COUNT];
    int low;
    root_vec_t roots;
    for (int u = 0; u < PU_COUNT; u++) begin
        label[u] = u;
    end
    for (int pass = 0; pass < PU_COUNT; pass++) begin
        for (int e = 0; e < EDGE_COUNT; e++) begin
            if (edge_growth[e] == NEIGHBOR_COST) begin
                low = (label[edge_a[e]] < label[edge_b[e]]) ? label[edge_a[e]] : label[edge_b[e]];
                label[edge_a[e]] = low;
                label[edge_b[e]] = low;
            end
        end
    end
    for (int u = 0; u < PU_COUNT; u++) begin
        roots[u] = PU_INDEX_WIDTH'(label[u]);
    end
    return roots;
endfunction

`endif

//--- tests/decoder_tb.sv
module decoder_tb;
    import decoder_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int TEST_COUNT = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int RANDOM_ROUNDS = 20;

    `include "decoder_model.svh"

    logic                                   clk;
    logic                                   reset;
    stage_e                                 stage_i;
    logic [PU_COUNT-1:0]                    is_error_syndrome_i;
    wire  [PU_COUNT-1:0][PU_INDEX_WIDTH-1:0] root_o;
    wire  [PU_COUNT-1:0]                    is_occupied_o;
    wire  [PU_COUNT-1:0]                    is_touching_boundary_o;
    wire                                    busy_o;

    root_vec_t           exp_root;
    logic [PU_COUNT-1:0] exp_occupied;
    logic [PU_COUNT-1:0] exp_touching;
    logic                check_en;

    integer seed;
    int     error_count;
    int     test_errors_at_start;
    int     tests_run;
    int     tests_failed;

    union_find_decoder UUT (
        .clk                    (clk),
        .reset                  (reset),
        .stage_i                (stage_i),
        .is_error_syndrome_i    (is_error_syndrome_i),
        .root_o                 (root_o),
        .is_occupied_o          (is_occupied_o),
        .is_touching_boundary_o (is_touching_boundary_o),
        .busy_o                 (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // check_en is a one cycle strobe raised while the outputs are stable
    root_matches: assert property (
        @(posedge clk) disable iff (reset)
        check_en |-> (root_o == exp_root)
    ) else begin
        error_count++;
        $display("MISMATCH root_o: got %h expected %h", root_o, exp_root);
    end

    occupied_matches: assert property (
        @(posedge clk) disable iff (reset)
        check_en |-> (is_occupied_o == exp_occupied)
    ) else begin
        error_count++;
        $display("MISMATCH is_occupied_o: got %h expected %h", is_occupied_o, exp_occupied);
    end

    touching_matches: assert property (
        @(posedge clk) disable iff (reset)
        check_en |-> (is_touching_boundary_o == exp_touching)
    ) else begin
        error_count++;
        $display("MISMATCH is_touching_boundary_o: got %h expected %h",
            is_touching_boundary_o, exp_touching);
    end

    busy_settled: assert property (
        @(posedge clk) disable iff (reset)
        check_en |-> !busy_o
    ) else begin
        error_count++;
        $display("MISMATCH busy_o: got %h expected %h", busy_o, 1'b0);
    end

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    // roots only move in a merge, so the expected roots follow loads and merges
    task automatic load_syndromes(logic [PU_COUNT-1:0] syndromes);
        is_error_syndrome_i = syndromes;
        stage_i = STAGE_MEASUREMENT_LOADING;
        step_cycle();
        step_cycle();
        stage_i = STAGE_IDLE;
        model_load(syndromes);
        exp_root = model_roots();
    endtask

    // the idle cycle lets the next GROW visit count as a new step
    task automatic grow_step();
        stage_i = STAGE_GROW;
        step_cycle();
        step_cycle();
        stage_i = STAGE_IDLE;
        step_cycle();
        model_grow();
    endtask

    task automatic merge_roots();
        int waited;
        waited = 0;
        stage_i = STAGE_MERGE;
        repeat (3) step_cycle();
        while (busy_o && waited < PU_COUNT) begin
            step_cycle();
            waited++;
        end
        if (busy_o) begin
            error_count++;
            $display("busy_o never fell during merge, roots did not settle");
        end
        stage_i = STAGE_IDLE;
        exp_root = model_roots();
    endtask

    task automatic check_outputs();
        exp_occupied = model_occupied();
        exp_touching = model_touching();
        check_en = 1'b1;
        step_cycle();
        check_en = 1'b0;
    endtask

    task automatic begin_test();
        test_errors_at_start = error_count;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (error_count == test_errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                error_count - test_errors_at_start);
        end
    endtask

    initial begin
        #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [PU_COUNT-1:0] syndromes;
        int                  steps;
        seed = 32'hf20ad27c;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        check_en = 1'b0;
        reset = 1'b1;
        stage_i = STAGE_IDLE;
        is_error_syndrome_i = '0;
        if (build_edges() != EDGE_COUNT) begin
            error_count++;
            $display("lattice edge list does not match the edge count");
        end
        model_load('0);
        exp_root = model_roots();

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        begin_test();
        check_outputs();
        end_test("reset state");

        // column 0 unit in layer 1 has a boundary edge
        begin_test();
        load_syndromes(PU_COUNT'(1) << pu_index(1, 0, 1));
        grow_step();
        check_outputs();
        grow_step();
        check_outputs();
        end_test("single syndrome at boundary");

        begin_test();
        syndromes = '0;
        syndromes[pu_index(1, 0, 0)] = 1'b1;
        syndromes[pu_index(1, 1, 0)] = 1'b1;
        load_syndromes(syndromes);
        grow_step();
        merge_roots();
        check_outputs();
        end_test("adjacent pair merge");

        begin_test();
        for (int round = 0; round < RANDOM_ROUNDS; round++) begin
            syndromes = PU_COUNT'($random(seed) & $random(seed));
            steps = 1 + ($unsigned($random(seed)) % 3);
            load_syndromes(syndromes);
            for (int s = 0; s < steps; s++) begin
                grow_step();
                merge_roots();
                check_outputs();
            end
        end
        end_test("random syndrome patterns");

        // a merged lattice first, then a fresh load over it
        begin_test();
        load_syndromes(PU_COUNT'(12'h00c));
        grow_step();
        merge_roots();
        check_outputs();
        load_syndromes(PU_COUNT'($random(seed)));
        check_outputs();
        end_test("reload after merge");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
            error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
